// ==== common/cu_cache_cfg.svh ====
// Build-time configuration for the cache front end
// Widths, FIFO depths, thresholds and write-buffer credits
`ifndef CU_CACHE_CFG_SVH
`define CU_CACHE_CFG_SVH

// ----------------------------------------------------------------------
// Data path widths
// ----------------------------------------------------------------------
`define CU_DATA_W        32
`define CU_ADDR_W        32
`define CU_ID_W          8
// Low address bits dropped for the word address
`define CU_BYTE_W        2
`define CU_STRB_W        (`CU_DATA_W / 8)
`define CU_WADDR_W       (`CU_ADDR_W - `CU_BYTE_W)

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------
`define CU_FIFO_DEPTH    16
// Response FIFO level that stops issue
`define CU_PROG_THRESH   12
// Write-buffer credits and counter width
`define CU_WTBUF_DEPTH   4
`define CU_WTBUF_CNT_W   3

`endif

// ==== common/cu_cache_pkg.sv ====
// Shared types of the cache front end
// Requests, responses, descriptor, FIFO status, cache port and FSM state
`default_nettype none

`include "cu_cache_cfg.svh"

package cu_cache_pkg;

  // ----------------------------------------------------------------------
  // Commands and requests
  // ----------------------------------------------------------------------
  typedef enum logic [0:0] {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } mem_cmd_t;

  // Request as seen at the input port
  typedef struct packed {
    logic                  valid;
    mem_cmd_t              cmd;
    logic [`CU_ID_W-1:0]   id;
    logic [`CU_ADDR_W-1:0] addr;
    logic [`CU_DATA_W-1:0] wdata;
    logic [`CU_STRB_W-1:0] wstrb;
  } mem_req_t;

  // Request FIFO entry, word addressed
  typedef struct packed {
    mem_cmd_t               cmd;
    logic [`CU_ID_W-1:0]    id;
    logic [`CU_WADDR_W-1:0] addr;
    logic [`CU_DATA_W-1:0]  wdata;
    logic [`CU_STRB_W-1:0]  wstrb;
  } cache_req_t;

  // ----------------------------------------------------------------------
  // Responses
  // ----------------------------------------------------------------------
  typedef struct packed {
    mem_cmd_t              cmd;
    logic [`CU_ID_W-1:0]   id;
    logic [`CU_DATA_W-1:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic      valid;
    mem_resp_t payload;
  } resp_t;

  // Kernel descriptor, base byte address only
  typedef struct packed {
    logic                  valid;
    logic [`CU_ADDR_W-1:0] base;
  } desc_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic prog_full;
  } fifo_status_t;

  // ----------------------------------------------------------------------
  // Cache port
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic [`CU_WADDR_W-1:0] addr;
    logic [`CU_DATA_W-1:0]  wdata;
    logic [`CU_STRB_W-1:0]  wstrb;
  } cache_port_o_t;

  typedef struct packed {
    logic                  ready;
    logic                  rvalid;
    logic [`CU_DATA_W-1:0] rdata;
    logic                  wtb_empty;
  } cache_port_i_t;

  // Command FSM state and write-buffer credit count
  typedef enum logic [1:0] {
    ST_RESET = 2'd0,
    ST_READY = 2'd1,
    ST_READ  = 2'd2,
    ST_WRITE = 2'd3
  } cmd_state_t;

  typedef logic [`CU_WTBUF_CNT_W-1:0] credit_t;

endpackage : cu_cache_pkg

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO with typed payload
// Full, empty and programmable-full flags
`default_nettype none
`timescale 1ns/1ps

`include "cu_cache_cfg.svh"

module sync_fifo #(
  parameter type T           = logic,
  parameter int  DEPTH       = `CU_FIFO_DEPTH,
  parameter int  PROG_THRESH = `CU_PROG_THRESH
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       wr_en_i,
  input  T                           din_i,
  input  logic                       rd_en_i,
  output T                           dout_o,
  output cu_cache_pkg::fifo_status_t status_o,
  output logic                       valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset on the payload
  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_ok;
  logic             rd_ok;

  // Pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Pushes into a full FIFO are dropped
  assign wr_ok = wr_en_i & ~status_o.full;
  assign rd_ok = rd_en_i & ~status_o.empty;

  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and level
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_ok) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags straight from the level
  assign status_o.full      = (count == CNT_W'(DEPTH));
  assign status_o.empty     = (count == '0);
  assign status_o.prog_full = (count >= CNT_W'(PROG_THRESH));

  // Head entry shown without a read
  assign dout_o  = mem[rd_ptr];
  assign valid_o = ~status_o.empty;

endmodule : sync_fifo

`default_nettype wire

// ==== hdl/cache_req_in.sv ====
// Input side: descriptor latch, request register stage
// and mapping of memory requests to word-addressed cache requests
`default_nettype none
`timescale 1ns/1ps

`include "cu_cache_cfg.svh"

module cache_req_in (
  input  logic                     ap_clk,
  input  logic                     areset_control,
  input  cu_cache_pkg::desc_t      desc_i,
  input  cu_cache_pkg::mem_req_t   req_i,
  output logic                     push_o,
  output cu_cache_pkg::cache_req_t cache_req_o,
  output logic                     desc_valid_o
);

  cu_cache_pkg::desc_t    desc_q;
  cu_cache_pkg::mem_req_t req_q;
  logic [`CU_ADDR_W-1:0]  byte_addr;

  // ----------------------------------------------------------------------
  // Descriptor latch
  // ----------------------------------------------------------------------
  // Held until the next valid descriptor
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      desc_q <= '0;
    end else if (desc_i.valid) begin
      desc_q <= desc_i;
    end
  end

  assign desc_valid_o = desc_q.valid;

  // ----------------------------------------------------------------------
  // Stage 1, raw request
  // ----------------------------------------------------------------------
  // Only the valid bit is cleared on reset
  always_ff @(posedge ap_clk) begin
    req_q <= req_i;
    if (areset_control) begin
      req_q.valid <= 1'b0;
    end
  end

  // Kernel base plus request offset
  assign byte_addr = req_q.addr + desc_q.base;

  // ----------------------------------------------------------------------
  // Stage 2, mapped request into the FIFO
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      push_o <= 1'b0;
    end else begin
      push_o <= req_q.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    cache_req_o.cmd   <= req_q.cmd;
    cache_req_o.id    <= req_q.id;
    // Byte to word address
    cache_req_o.addr  <= byte_addr[`CU_ADDR_W-1:`CU_BYTE_W];
    cache_req_o.wdata <= req_q.wdata;
    cache_req_o.wstrb <= req_q.wstrb;
  end

endmodule : cache_req_in

`default_nettype wire

// ==== cache_ctrl/cache_cmd_fsm.sv ====
// Command FSM toward the cache port, read strobe masking
// and write-buffer credit counter
`default_nettype none
`timescale 1ns/1ps

`include "cu_cache_cfg.svh"

module cache_cmd_fsm (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        desc_valid_i,
  input  cu_cache_pkg::cache_req_t    head_i,
  input  logic                        head_valid_i,
  input  cu_cache_pkg::fifo_status_t  req_status_i,
  input  cu_cache_pkg::fifo_status_t  resp_status_i,
  input  cu_cache_pkg::cache_port_i_t cache_i,
  output logic                        pop_o,
  output cu_cache_pkg::cache_port_o_t cache_o,
  output logic                        resp_push_o,
  output cu_cache_pkg::mem_resp_t     resp_o
);

  cu_cache_pkg::cmd_state_t state_q;
  cu_cache_pkg::cmd_state_t state_d;
  cu_cache_pkg::credit_t    credit_q;
  logic                     is_write;
  logic                     head_ok;
  logic                     credit_ok;
  logic                     issue_rd;
  logic                     issue_wr;

  // ----------------------------------------------------------------------
  // Issue conditions
  // ----------------------------------------------------------------------
  assign is_write = (head_i.cmd == cu_cache_pkg::CMD_WRITE);

  // Head present, room for the response, kernel known, cache idle
  assign head_ok = head_valid_i & ~req_status_i.empty & ~resp_status_i.prog_full &
                   desc_valid_i & cache_i.ready;

  // Writes stall only on no credit with a busy write buffer
  assign credit_ok = (credit_q != '0) | cache_i.wtb_empty;
  assign issue_rd  = head_ok & ~is_write;
  assign issue_wr  = head_ok & is_write & credit_ok;

  // ----------------------------------------------------------------------
  // State register and next state
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state_q <= cu_cache_pkg::ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cu_cache_pkg::ST_RESET: state_d = cu_cache_pkg::ST_READY;
      cu_cache_pkg::ST_READY: begin
        if (issue_rd) begin
          state_d = cu_cache_pkg::ST_READ;
        end else if (issue_wr) begin
          state_d = cu_cache_pkg::ST_WRITE;
        end
      end
      // Read waits for read-valid, any latency
      cu_cache_pkg::ST_READ: begin
        if (cache_i.rvalid) begin
          state_d = cu_cache_pkg::ST_READY;
        end
      end
      // Write is a single cycle
      cu_cache_pkg::ST_WRITE: state_d = cu_cache_pkg::ST_READY;
      default: state_d = cu_cache_pkg::ST_RESET;
    endcase
  end

  // ----------------------------------------------------------------------
  // Cache port, FIFO pop and response push
  // ----------------------------------------------------------------------
  always_comb begin
    cache_o.valid = 1'b0;
    pop_o         = 1'b0;
    case (state_q)
      cu_cache_pkg::ST_READ: begin
        // Valid held until the data returns
        cache_o.valid = ~cache_i.rvalid;
        pop_o         = cache_i.rvalid;
      end
      cu_cache_pkg::ST_WRITE: begin
        cache_o.valid = 1'b1;
        pop_o         = 1'b1;
      end
      default: begin
        cache_o.valid = 1'b0;
        pop_o         = 1'b0;
      end
    endcase
    cache_o.addr  = head_i.addr;
    cache_o.wdata = head_i.wdata;
    // No strobes on reads
    cache_o.wstrb = head_i.wstrb & {`CU_STRB_W{is_write}};
    resp_o.cmd    = head_i.cmd;
    resp_o.id     = head_i.id;
    // Write responses carry zero data
    resp_o.rdata  = (state_q == cu_cache_pkg::ST_READ) ? cache_i.rdata : '0;
  end

  // Every pop completes one command and yields one response
  assign resp_push_o = pop_o;

  // ----------------------------------------------------------------------
  // Write-buffer credits
  // ----------------------------------------------------------------------
  // Full reload in reset state or while the buffer drains
  always_ff @(posedge ap_clk) begin
    if (areset_control || (state_q == cu_cache_pkg::ST_RESET) || cache_i.wtb_empty) begin
      credit_q <= cu_cache_pkg::credit_t'(`CU_WTBUF_DEPTH);
    end else if ((state_q == cu_cache_pkg::ST_WRITE) && (credit_q != '0)) begin
      credit_q <= credit_q - 1'b1;
    end
  end

endmodule : cache_cmd_fsm

`default_nettype wire

// ==== hdl/cache_resp_out.sv ====
// Output side: response pop gating, output and status registers,
// done detection
`default_nettype none
`timescale 1ns/1ps

module cache_resp_out (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       resp_rd_en_i,
  input  cu_cache_pkg::mem_resp_t    head_i,
  input  logic                       head_valid_i,
  input  cu_cache_pkg::fifo_status_t req_status_i,
  input  cu_cache_pkg::fifo_status_t resp_status_i,
  input  logic                       cache_ready_i,
  input  logic                       wtb_empty_i,
  output logic                       pop_o,
  output cu_cache_pkg::resp_t        resp_o,
  output cu_cache_pkg::fifo_status_t req_status_o,
  output cu_cache_pkg::fifo_status_t resp_status_o,
  output logic                       done_o
);

  logic rd_en_q;
  logic idle;
  logic idle_q;

  // ----------------------------------------------------------------------
  // Consumer pop
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= resp_rd_en_i;
    end
  end

  // Registered strobe, ignored on an empty FIFO
  assign pop_o = rd_en_q & ~resp_status_i.empty;

  // ----------------------------------------------------------------------
  // Output and status registers
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_o.valid  <= 1'b0;
      req_status_o  <= '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};
      resp_status_o <= '{full: 1'b0, empty: 1'b1, prog_full: 1'b0};
    end else begin
      resp_o.valid  <= pop_o & head_valid_i;
      req_status_o  <= req_status_i;
      resp_status_o <= resp_status_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    resp_o.payload <= head_i;
  end

  // ----------------------------------------------------------------------
  // Done
  // ----------------------------------------------------------------------
  // Nothing buffered and the cache fully drained
  assign idle = req_status_i.empty & resp_status_i.empty & cache_ready_i & wtb_empty_i;

  // Two cycles of idle, drops as soon as idle goes away
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      idle_q <= 1'b0;
      done_o <= 1'b0;
    end else begin
      idle_q <= idle;
      done_o <= idle_q & idle;
    end
  end

endmodule : cache_resp_out

`default_nettype wire

// ==== hdl/cu_cache.sv ====
// Cache front end top level
// Input side, request FIFO, command FSM, response FIFO, output side
`default_nettype none
`timescale 1ns/1ps

module cu_cache (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  cu_cache_pkg::desc_t         desc_i,
  input  cu_cache_pkg::mem_req_t      req_i,
  input  logic                        resp_rd_en_i,
  input  cu_cache_pkg::cache_port_i_t cache_i,
  output cu_cache_pkg::resp_t         resp_o,
  output cu_cache_pkg::fifo_status_t  req_status_o,
  output cu_cache_pkg::fifo_status_t  resp_status_o,
  output cu_cache_pkg::cache_port_o_t cache_o,
  output logic                        done_o
);

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  logic                       req_push;
  cu_cache_pkg::cache_req_t   req_din;
  cu_cache_pkg::cache_req_t   req_head;
  logic                       req_head_valid;
  logic                       req_pop;
  cu_cache_pkg::fifo_status_t req_status;
  logic                       desc_valid;

  // Response path
  logic                       resp_push;
  cu_cache_pkg::mem_resp_t    resp_din;
  cu_cache_pkg::mem_resp_t    resp_head;
  logic                       resp_head_valid;
  logic                       resp_pop;
  cu_cache_pkg::fifo_status_t resp_status;

  cache_req_in u_req_in (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_i        (desc_i),
    .req_i         (req_i),
    .push_o        (req_push),
    .cache_req_o   (req_din),
    .desc_valid_o  (desc_valid)
  );

  sync_fifo #(.T(cu_cache_pkg::cache_req_t)) req_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (req_push),
    .din_i         (req_din),
    .rd_en_i       (req_pop),
    .dout_o        (req_head),
    .status_o      (req_status),
    .valid_o       (req_head_valid)
  );

  // ----------------------------------------------------------------------
  // Command issue toward the cache
  // ----------------------------------------------------------------------
  cache_cmd_fsm u_cmd_fsm (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_valid_i  (desc_valid),
    .head_i        (req_head),
    .head_valid_i  (req_head_valid),
    .req_status_i  (req_status),
    .resp_status_i (resp_status),
    .cache_i       (cache_i),
    .pop_o         (req_pop),
    .cache_o       (cache_o),
    .resp_push_o   (resp_push),
    .resp_o        (resp_din)
  );

  sync_fifo #(.T(cu_cache_pkg::mem_resp_t)) resp_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en_i       (resp_push),
    .din_i         (resp_din),
    .rd_en_i       (resp_pop),
    .dout_o        (resp_head),
    .status_o      (resp_status),
    .valid_o       (resp_head_valid)
  );

  // ----------------------------------------------------------------------
  // Consumer side
  // ----------------------------------------------------------------------
  cache_resp_out u_resp_out (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .resp_rd_en_i  (resp_rd_en_i),
    .head_i        (resp_head),
    .head_valid_i  (resp_head_valid),
    .req_status_i  (req_status),
    .resp_status_i (resp_status),
    .cache_ready_i (cache_i.ready),
    .wtb_empty_i   (cache_i.wtb_empty),
    .pop_o         (resp_pop),
    .resp_o        (resp_o),
    .req_status_o  (req_status_o),
    .resp_status_o (resp_status_o),
    .done_o        (done_o)
  );

endmodule : cu_cache

`default_nettype wire

// ==== test/cu_cache_chk.sv ====
// Port-level assertions for the cache front end, bound to the top level
`default_nettype none
`timescale 1ns/1ps

module cu_cache_chk (
  input logic                        ap_clk,
  input logic                        areset_control,
  input cu_cache_pkg::cache_port_i_t cache_rsp_i,
  input cu_cache_pkg::cache_port_o_t cache_req_i,
  input cu_cache_pkg::resp_t         resp_i,
  input cu_cache_pkg::fifo_status_t  req_status_i,
  input logic                        done_i
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  // A waiting read keeps its address, nothing new starts
  read_wait_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    cache_req_i.valid && !cache_rsp_i.rvalid |=> !cache_req_i.valid || $stable(cache_req_i.addr))
    else begin
      fail_count++;
      $error("cache command started while a read was pending");
    end

  // No response out of reset
  reset_resp_a: assert property (@(posedge ap_clk) areset_control |=> !resp_i.valid)
    else begin
      fail_count++;
      $error("response valid right after reset");
    end

  done_empty_a: assert property (@(posedge ap_clk) disable iff (areset_control)
    !req_status_i.empty |-> !done_i)
    else begin
      fail_count++;
      $error("done high with requests still queued");
    end

endmodule : cu_cache_chk

bind cu_cache cu_cache_chk chk (
  .ap_clk        (ap_clk),
  .areset_control(areset_control),
  .cache_rsp_i   (cache_i),
  .cache_req_i   (cache_o),
  .resp_i        (resp_o),
  .req_status_i  (req_status_o),
  .done_i        (done_o)
);

`default_nettype wire

// ==== test/tb_cu_cache.sv ====
// Testbench for the cache front end with clock, reset, random stimulus,
// cache memory model, reference model, compare tasks and watchdog
`default_nettype none
`timescale 1ns/1ps

`include "cu_cache_cfg.svh"

module tb_cu_cache;

  // Requests over all phases for the watchdog
  localparam int N_REQ   = 92;
  // Requests allowed between the input port and the cache
  localparam int MAX_OUT = 8;

  logic                        ap_clk;
  logic                        areset_control;
  cu_cache_pkg::desc_t         desc_i;
  cu_cache_pkg::mem_req_t      req_i;
  logic                        resp_rd_en_i;
  cu_cache_pkg::cache_port_i_t cache_i;
  cu_cache_pkg::resp_t         resp_o;
  cu_cache_pkg::fifo_status_t  req_status_o;
  cu_cache_pkg::fifo_status_t  resp_status_o;
  cu_cache_pkg::cache_port_o_t cache_o;
  logic                        done_o;

  // Reference model in request order
  cu_cache_pkg::mem_resp_t     exp_resp [$];
  cu_cache_pkg::cache_port_o_t exp_issue [$];
  logic                        exp_is_wr [$];
  logic [`CU_DATA_W-1:0]       shadow_mem [16];
  // Cache model storage
  logic [`CU_DATA_W-1:0]       cache_mem [16];
  logic [31:0]                 rng;
  logic [`CU_ADDR_W-1:0]       cur_base;
  int                          sent;
  int                          issued;
  int                          wr_burst;
  int                          rd_wait;
  int                          phase_start;
  int                          wtb_mode;
  int                          cons_mode;
  logic                        desc_sent;
  logic                        prev_valid;
  logic                        rd_pending;
  logic                        hold_idle;
  logic [3:0]                  rd_idx;

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  cu_cache uut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .desc_i        (desc_i),
    .req_i         (req_i),
    .resp_rd_en_i  (resp_rd_en_i),
    .cache_i       (cache_i),
    .resp_o        (resp_o),
    .req_status_o  (req_status_o),
    .resp_status_o (resp_status_o),
    .cache_o       (cache_o),
    .done_o        (done_o)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Start contents with every word different
  function automatic logic [`CU_DATA_W-1:0] fill_word(input int i);
    return 32'hC0DE_0000 ^ (32'(i) * 32'h0104_0911);
  endfunction

  function automatic logic [`CU_DATA_W-1:0] merge_strb(input logic [`CU_DATA_W-1:0] old_w,
                                                        input logic [`CU_DATA_W-1:0] new_w,
                                                        input logic [`CU_STRB_W-1:0] strb);
    logic [`CU_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < `CU_STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_resp(input string name, input cu_cache_pkg::mem_resp_t exp,
                            input cu_cache_pkg::mem_resp_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_cache_req(input string name, input cu_cache_pkg::cache_port_o_t exp,
                                 input cu_cache_pkg::cache_port_o_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input cu_cache_pkg::fifo_status_t exp,
                              input cu_cache_pkg::fifo_status_t act);
    if (act !== exp) begin
      report_failure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitor and cache model sampled before the new drive
  // ----------------------------------------------------------------------
  task automatic observe();
    cu_cache_pkg::cache_port_o_t exp_port;
    logic                        is_wr;
    if (uut.chk.fail_count != 0) begin
      report_failure("An assertion on the DUT ports failed");
    end
    if (resp_o.valid) begin
      if (exp_resp.size() == 0) begin
        report_failure("A response arrived with no request outstanding");
      end
      check_resp("response", exp_resp.pop_front(), resp_o.payload);
    end
    // Credits reload on each edge that saw an empty write buffer
    if (cache_i.wtb_empty) begin
      wr_burst = 0;
    end
    if (cache_o.valid && !prev_valid) begin
      if (!desc_sent) begin
        report_failure("A cache command was issued before the descriptor");
      end
      if (exp_issue.size() == 0) begin
        report_failure("A cache command was issued with no request pending");
      end
      exp_port = exp_issue.pop_front();
      is_wr    = exp_is_wr.pop_front();
      check_cache_req("cache request", exp_port, cache_o);
      issued++;
      if (is_wr) begin
        cache_mem[cache_o.addr[3:0]] = merge_strb(cache_mem[cache_o.addr[3:0]],
                                                  cache_o.wdata, cache_o.wstrb);
        wr_burst++;
        if (wr_burst > `CU_WTBUF_DEPTH) begin
          report_failure("A write was issued with no write-buffer credit left");
        end
      end else begin
        rd_pending = 1'b1;
        rd_idx     = cache_o.addr[3:0];
        rd_wait    = int'(next_rand() % 32'd4);
      end
    end
    prev_valid = cache_o.valid;
  endtask

  task automatic drive_cache();
    logic [31:0] r;
    r = next_rand();
    cache_i.rvalid = 1'b0;
    cache_i.rdata  = '0;
    // Read data after a random wait
    if (rd_pending) begin
      if (rd_wait == 0) begin
        cache_i.rvalid = 1'b1;
        cache_i.rdata  = cache_mem[rd_idx];
        rd_pending     = 1'b0;
      end else begin
        rd_wait--;
      end
    end
    cache_i.ready = hold_idle | (r[1:0] != 2'b00);
    case (wtb_mode)
      1:       cache_i.wtb_empty = 1'b0;
      2:       cache_i.wtb_empty = 1'b1;
      default: cache_i.wtb_empty = (r[4:2] == 3'b000);
    endcase
    // Consumer off, random or always popping
    resp_rd_en_i = (cons_mode == 2) | ((cons_mode == 1) & r[5]);
  endtask

  task automatic tick();
    @(negedge ap_clk);
    observe();
    drive_cache();
    req_i.valid  = 1'b0;
    desc_i.valid = 1'b0;
  endtask

  // One request with its expected command and response
  task automatic send_req(input logic only_wr);
    logic [31:0]                 r;
    logic [`CU_ADDR_W-1:0]       byte_addr;
    logic [3:0]                  idx;
    cu_cache_pkg::cache_port_o_t port;
    cu_cache_pkg::mem_resp_t     rsp;
    tick();
    while (sent - issued >= MAX_OUT) begin
      tick();
    end
    r = next_rand();
    req_i.valid = 1'b1;
    req_i.cmd   = (only_wr | r[0]) ? cu_cache_pkg::CMD_WRITE : cu_cache_pkg::CMD_READ;
    req_i.id    = `CU_ID_W'(sent);
    req_i.addr  = `CU_ADDR_W'(r[9:0]);
    req_i.wdata = next_rand();
    req_i.wstrb = `CU_STRB_W'(r >> 12);
    byte_addr   = req_i.addr + cur_base;
    port.valid  = 1'b1;
    port.addr   = byte_addr[`CU_ADDR_W-1:`CU_BYTE_W];
    port.wdata  = req_i.wdata;
    port.wstrb  = (req_i.cmd == cu_cache_pkg::CMD_WRITE) ? req_i.wstrb : '0;
    idx         = port.addr[3:0];
    rsp.cmd     = req_i.cmd;
    rsp.id      = req_i.id;
    if (req_i.cmd == cu_cache_pkg::CMD_WRITE) begin
      rsp.rdata       = '0;
      shadow_mem[idx] = merge_strb(shadow_mem[idx], req_i.wdata, req_i.wstrb);
    end else begin
      rsp.rdata = shadow_mem[idx];
    end
    exp_issue.push_back(port);
    exp_is_wr.push_back(req_i.cmd == cu_cache_pkg::CMD_WRITE);
    exp_resp.push_back(rsp);
    sent++;
  endtask

  task automatic wait_drained();
    while (exp_resp.size() != 0) begin
      tick();
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    rng            = 32'd98605;
    areset_control = 1'b1;
    desc_i         = '0;
    req_i          = '0;
    resp_rd_en_i   = 1'b0;
    cache_i        = '0;
    cur_base       = '0;
    sent           = 0;
    issued         = 0;
    wr_burst       = 0;
    rd_wait        = 0;
    phase_start    = 0;
    wtb_mode       = 0;
    cons_mode      = 1;
    desc_sent      = 1'b0;
    prev_valid     = 1'b0;
    rd_pending     = 1'b0;
    hold_idle      = 1'b0;
    rd_idx         = '0;
    for (int i = 0; i < 16; i++) begin
      shadow_mem[i] = fill_word(i);
      cache_mem[i]  = fill_word(i);
    end
    repeat (8) @(posedge ap_clk);
    @(negedge ap_clk);
    areset_control = 1'b0;
    tick();
    check_status("request status after reset", '{1'b0, 1'b1, 1'b0}, req_status_o);
    check_status("response status after reset", '{1'b0, 1'b1, 1'b0}, resp_status_o);

    // Held in the request FIFO and mapped with a zero base
    repeat (4) send_req(1'b0);
    repeat (30) tick();
    check_status("request FIFO before descriptor", '{1'b0, 1'b0, 1'b0}, req_status_o);
    tick();
    desc_i.valid = 1'b1;
    desc_i.base  = next_rand();
    cur_base     = desc_i.base;
    desc_sent    = 1'b1;

    // Random mix
    repeat (60) begin
      send_req(1'b0);
      repeat (next_rand() % 32'd3) tick();
    end
    wait_drained();

    // Consumer stalled until issue stops at prog_full
    cons_mode   = 0;
    phase_start = issued;
    repeat (20) send_req(1'b0);
    repeat (20) tick();
    if (issued - phase_start != `CU_PROG_THRESH) begin
      report_failure("Issue did not stop when the response FIFO reached prog_full");
    end
    check_status("response FIFO at prog_full", '{1'b0, 1'b0, 1'b1}, resp_status_o);
    cons_mode = 2;
    wait_drained();

    // Write buffer busy until the credits run out
    wtb_mode = 2;
    repeat (4) tick();
    wtb_mode    = 1;
    phase_start = issued;
    repeat (8) send_req(1'b1);
    while (issued - phase_start < `CU_WTBUF_DEPTH) begin
      tick();
    end
    repeat (30) tick();
    if (issued - phase_start != `CU_WTBUF_DEPTH) begin
      report_failure("Writes kept issuing after the write-buffer credits ran out");
    end
    wtb_mode = 0;
    wait_drained();

    // Idle cache raises done
    hold_idle = 1'b1;
    wtb_mode  = 2;
    while (!done_o) begin
      tick();
    end
    check_status("request status at done", '{1'b0, 1'b1, 1'b0}, req_status_o);
    check_status("response status at done", '{1'b0, 1'b1, 1'b0}, resp_status_o);
    if (issued != sent) begin
      report_failure("The number of cache commands differs from the number of requests");
    end

    if (uut.chk.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      report_failure("An assertion on the DUT ports failed");
    end
  end

  // Watchdog
  initial begin
    repeat (N_REQ * 200) @(posedge ap_clk);
    report_failure("Timeout: the run did not complete in time");
  end

endmodule : tb_cu_cache

`default_nettype wire

// ==== all.f ====
+incdir+common
common/cu_cache_pkg.sv
hdl/sync_fifo.sv
hdl/cache_req_in.sv
cache_ctrl/cache_cmd_fsm.sv
hdl/cache_resp_out.sv
hdl/cu_cache.sv
test/cu_cache_chk.sv
test/tb_cu_cache.sv
